// File: hdl/cart_pkg.sv
// Cartridge control package
// Shared widths, header offsets, default size codes and the enums used by
// the cartridge header detector and the backup RAM sequencer

package cart_pkg;

	// ==================================================
	// Loader and SD widths
	// ==================================================
	localparam int unsigned load_addr_w  = 25;
	localparam int unsigned load_data_w  = 16;
	// All ones marks a cheat file
	localparam int unsigned load_index_w = 8;
	localparam int unsigned mask_w       = 24;
	localparam int unsigned lba_w        = 32;
	localparam int unsigned img_size_w   = 64;
	// Flags, address, compare and replace each use this width
	localparam int unsigned cheat_w      = 32;

	// ==================================================
	// Header layout
	// ==================================================
	// Copier prefix in front of the ROM image
	localparam int unsigned copier_hdr_bytes = 512;

	// ROM size byte in the upper half of the word at the base
	localparam int unsigned lorom_hdr_addr   = 'h7FD6 + copier_hdr_bytes;
	localparam int unsigned hirom_hdr_addr   = 'hFFD6 + copier_hdr_bytes;
	localparam int unsigned exhirom_hdr_addr = 'h40FFD6 + copier_hdr_bytes;

	// Each size code doubles this unit
	localparam int unsigned default_rom_size = 12;
	localparam int unsigned size_unit        = 1024;

	// ==================================================
	// Enums
	// ==================================================
	typedef enum logic [2:0] {
		hdr_auto    = 3'd0,
		hdr_none    = 3'd1,
		hdr_lorom   = 3'd2,
		hdr_hirom   = 3'd3,
		hdr_exhirom = 3'd4
	} header_mode_e;

	// Backup RAM sector sequencer
	typedef enum logic [1:0] {
		bk_idle,
		bk_request,
		bk_transfer
	} bk_state_e;

endpackage

// File: hdl/cart_header_detect.sv
// Cartridge header detector
// Watches the loader word stream during a cartridge load and derives the
// ROM type, the ROM and RAM address masks and the video region.
// A forced header mode overrides the size codes found in the file

`timescale 1ns/100ps

module cart_header_detect (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               cart_load,
	input  logic                               load_wr,
	input  logic [cart_pkg::load_addr_w-1:0]   load_addr,
	input  logic [cart_pkg::load_data_w-1:0]   load_data,
	input  cart_pkg::header_mode_e             header_mode,
	output logic [7:0]                         rom_type,
	output logic                               rom_region,
	output logic [cart_pkg::mask_w-1:0]        rom_mask,
	output logic [cart_pkg::mask_w-1:0]        ram_mask
);

	import cart_pkg::*;

	logic [3:0]             rom_size;
	logic [3:0]             ram_size;
	logic                   hdr_forced;
	logic [load_addr_w-1:0] hdr_rom_addr;
	logic [load_addr_w-1:0] hdr_ram_addr;

	// ==================================================
	// Header location for the forced modes
	// ==================================================
	always_comb begin
		hdr_forced   = 1'b1;
		hdr_rom_addr = '0;
		case (header_mode)
			hdr_lorom:   hdr_rom_addr = load_addr_w'(lorom_hdr_addr);
			hdr_hirom:   hdr_rom_addr = load_addr_w'(hirom_hdr_addr);
			hdr_exhirom: hdr_rom_addr = load_addr_w'(exhirom_hdr_addr);
			default:     hdr_forced = 1'b0;
		endcase
	end

	// RAM size nibble is one word past the ROM size byte
	assign hdr_ram_addr = hdr_rom_addr + load_addr_w'(2);

	// ==================================================
	// Field capture
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
			rom_size   <= 4'(default_rom_size);
			ram_size   <= 4'd0;
		end else if (cart_load && load_wr) begin
			if (load_addr == '0) begin
				rom_size <= 4'(default_rom_size);
				ram_size <= 4'd0;
				// Auto mode takes the sizes from the loader's own prefix
				if (header_mode == hdr_auto && load_data[7:0] != 8'd0) begin
					{ram_size, rom_size} <= load_data[7:0];
				end
				case (header_mode)
					hdr_none,
					hdr_lorom:   rom_type <= 8'd0;
					hdr_hirom:   rom_type <= 8'd1;
					hdr_exhirom: rom_type <= 8'd2;
					default:     rom_type <= load_data[15:8];
				endcase
			end

			if (load_addr == load_addr_w'(2)) begin
				rom_region <= load_data[8];
			end

			if (hdr_forced && load_addr == hdr_rom_addr) begin
				rom_size <= load_data[11:8];
			end
			if (hdr_forced && load_addr == hdr_ram_addr) begin
				ram_size <= load_data[3:0];
			end
		end
	end

	// Masks follow the registered size codes
	assign rom_mask = (mask_w'(size_unit) << rom_size) - mask_w'(1);
	assign ram_mask = (ram_size != 4'd0) ? (mask_w'(size_unit) << ram_size) - mask_w'(1) : '0;

endmodule

// File: hdl/cheat_code_loader.sv
// Cheat code loader
// Collects the eight 16-bit words of a cheat record into the flags,
// address, compare and replace fields and pulses valid when complete

`timescale 1ns/100ps

module cheat_code_loader (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic                             code_load,
	input  logic                             cart_load,
	input  logic                             load_wr,
	input  logic [cart_pkg::load_addr_w-1:0] load_addr,
	input  logic [cart_pkg::load_data_w-1:0] load_data,
	output logic [cart_pkg::cheat_w-1:0]     cheat_flags,
	output logic [cart_pkg::cheat_w-1:0]     cheat_addr,
	output logic [cart_pkg::cheat_w-1:0]     cheat_compare,
	output logic [cart_pkg::cheat_w-1:0]     cheat_replace,
	output logic                             cheat_valid,
	output logic                             cheat_reset
);

	import cart_pkg::*;

	localparam int unsigned half_w = cheat_w / 2;

	logic code_wr;

	assign code_wr = code_load && load_wr;

	// Record fields take the low half first in each pair
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (load_addr[3:0])
				4'd0:  cheat_flags[half_w-1:0]         <= load_data;
				4'd2:  cheat_flags[cheat_w-1:half_w]   <= load_data;
				4'd4:  cheat_addr[half_w-1:0]          <= load_data;
				4'd6:  cheat_addr[cheat_w-1:half_w]    <= load_data;
				4'd8:  cheat_compare[half_w-1:0]       <= load_data;
				4'd10: cheat_compare[cheat_w-1:half_w] <= load_data;
				4'd12: cheat_replace[half_w-1:0]       <= load_data;
				4'd14: cheat_replace[cheat_w-1:half_w] <= load_data;
				default: ;
			endcase
		end
	end

	// Last word of the record clocks the code in
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (load_addr[3:0] == 4'd14);
		end
	end

	// Cheat list clears on a new cartridge or a fresh cheat file
	assign cheat_reset = cart_load || (code_wr && load_addr == '0);

	a_valid_single: assert property (
		@(posedge clk_sys) disable iff (!reset) cheat_valid |=> !cheat_valid);

endmodule

// File: hdl/backup_ram_sync.sv
// Backup RAM synchroniser
// Tracks unsaved writes to the cartridge backup RAM and moves it to or
// from the SD image one sector at a time. Covers manual load and save,
// autoload at the end of a cartridge load and autosave on menu open

`timescale 1ns/100ps

module backup_ram_sync (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              cart_load,
	input  logic [cart_pkg::mask_w-1:0]       ram_mask,
	input  logic                              img_mounted,
	input  logic                              img_readonly,
	input  logic [cart_pkg::img_size_w-1:0]   img_size,
	input  logic                              osd_open,
	input  logic                              autosave_en,
	input  logic                              sram_write,
	input  logic                              bk_load_req,
	input  logic                              bk_save_req,
	input  logic                              sd_ack,
	output logic [cart_pkg::lba_w-1:0]        sd_lba,
	output logic                              sd_rd,
	output logic                              sd_wr,
	output logic                              bk_busy,
	output logic                              bk_loading,
	output logic                              save_led
);

	import cart_pkg::*;

	bk_state_e state;

	logic bk_ena;
	logic pending;
	logic old_cart_load;
	logic old_load;
	logic old_save;
	logic old_ack;
	logic save_cond;
	logic load_edge;
	logic save_edge;
	logic autoload;
	logic ack_rise;
	logic ack_fall;
	logic last_sector;

	// ==================================================
	// Trigger and handshake edges
	// ==================================================
	assign save_cond = bk_save_req || (pending && osd_open && autosave_en);
	assign load_edge = bk_load_req && bk_ena && !old_load;
	assign save_edge = save_cond && bk_ena && !old_save;
	assign autoload  = old_cart_load && !cart_load && (img_size != '0) && bk_ena;
	assign ack_rise  = sd_ack && !old_ack;
	assign ack_fall  = !sd_ack && old_ack;

	assign last_sector = sd_lba >= lba_w'(ram_mask[23:9]);
	assign bk_busy     = (state != bk_idle);
	assign save_led    = cart_load || (pending && autosave_en);

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			old_cart_load <= 1'b0;
			old_load      <= 1'b0;
			old_save      <= 1'b0;
			old_ack       <= 1'b0;
		end else begin
			old_cart_load <= cart_load;
			old_load      <= bk_load_req && bk_ena;
			old_save      <= save_cond && bk_ena;
			old_ack       <= sd_ack;
		end
	end

	// Save image is mounted while the cartridge is still loading
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_ena <= 1'b0;
		end else begin
			if (cart_load && !old_cart_load) begin
				bk_ena <= 1'b0;
			end
			if (cart_load && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end
		end
	end

	// Unsaved writes are dropped once a transfer is under way
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			pending <= 1'b0;
		end else if (bk_ena && !osd_open && sram_write) begin
			pending <= 1'b1;
		end else if (bk_busy) begin
			pending <= 1'b0;
		end
	end

	// ==================================================
	// Sector sequencer
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state      <= bk_idle;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			case (state)
				bk_idle: begin
					if (autoload) begin
						state      <= bk_request;
						sd_lba     <= '0;
						sd_rd      <= 1'b1;
						sd_wr      <= 1'b0;
						bk_loading <= 1'b1;
					end else if (load_edge || save_edge) begin
						state      <= bk_request;
						sd_lba     <= '0;
						sd_rd      <= load_edge;
						sd_wr      <= !load_edge;
						bk_loading <= load_edge;
					end
				end
				bk_request: begin
					// Device has taken the request
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= bk_transfer;
					end
				end
				bk_transfer: begin
					if (ack_fall) begin
						if (last_sector) begin
							state      <= bk_idle;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + lba_w'(1);
							sd_rd  <= bk_loading;
							sd_wr  <= !bk_loading;
							state  <= bk_request;
						end
					end
				end
				default: state <= bk_idle;
			endcase
		end
	end

	a_rd_wr_excl: assert property (
		@(posedge clk_sys) disable iff (!reset) !(sd_rd && sd_wr));

	a_lba_in_range: assert property (
		@(posedge clk_sys) disable iff (!reset)
		bk_busy |-> (sd_lba <= lba_w'(ram_mask[23:9])));

endmodule

// File: hdl/cart_control_top.sv
// Cartridge control top
// Splits the loader stream into cartridge and cheat loads and ties the
// header detector, the cheat loader and the backup RAM sequencer together

`timescale 1ns/100ps

module cart_control_top (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              load_active,
	input  logic [cart_pkg::load_index_w-1:0] load_index,
	input  logic [cart_pkg::load_addr_w-1:0]  load_addr,
	input  logic [cart_pkg::load_data_w-1:0]  load_data,
	input  logic                              load_wr,
	input  cart_pkg::header_mode_e            header_mode,
	input  logic                              autosave_en,
	input  logic                              osd_open,
	input  logic                              bk_load_req,
	input  logic                              bk_save_req,
	input  logic                              sram_write,
	input  logic                              img_mounted,
	input  logic                              img_readonly,
	input  logic [cart_pkg::img_size_w-1:0]   img_size,
	input  logic                              sd_ack,
	output logic [7:0]                        rom_type,
	output logic                              rom_region,
	output logic [cart_pkg::mask_w-1:0]       rom_mask,
	output logic [cart_pkg::mask_w-1:0]       ram_mask,
	output logic [cart_pkg::cheat_w-1:0]      cheat_flags,
	output logic [cart_pkg::cheat_w-1:0]      cheat_addr,
	output logic [cart_pkg::cheat_w-1:0]      cheat_compare,
	output logic [cart_pkg::cheat_w-1:0]      cheat_replace,
	output logic                              cheat_valid,
	output logic                              cheat_reset,
	output logic [cart_pkg::lba_w-1:0]        sd_lba,
	output logic                              sd_rd,
	output logic                              sd_wr,
	output logic                              bk_busy,
	output logic                              bk_loading,
	output logic                              save_led,
	output logic                              core_hold
);

	logic code_index;
	logic cart_load;
	logic code_load;

	// Index of all ones carries a cheat file
	assign code_index = &load_index;
	assign cart_load  = load_active && !code_index;
	assign code_load  = load_active && code_index;

	// Core stays stopped while its ROM or backup RAM is being filled
	assign core_hold = cart_load || bk_loading || !reset;

	cart_header_detect u_header (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cart_load   (cart_load),
		.load_wr     (load_wr),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.header_mode (header_mode),
		.rom_type    (rom_type),
		.rom_region  (rom_region),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask)
	);

	cheat_code_loader u_cheat (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_load     (code_load),
		.cart_load     (cart_load),
		.load_wr       (load_wr),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.cheat_flags   (cheat_flags),
		.cheat_addr    (cheat_addr),
		.cheat_compare (cheat_compare),
		.cheat_replace (cheat_replace),
		.cheat_valid   (cheat_valid),
		.cheat_reset   (cheat_reset)
	);

	backup_ram_sync u_backup (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_load    (cart_load),
		.ram_mask     (ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.osd_open     (osd_open),
		.autosave_en  (autosave_en),
		.sram_write   (sram_write),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading),
		.save_led     (save_led)
	);

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock and reset source
// Makes clk_sys with an 8 ns period and holds the active-low reset
// for the first ten rising edges

`timescale 1ns/100ps

module tb_clock_gen #(
	parameter realtime period       = 8.0,
	parameter int      reset_cycles = 10
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(period / 2.0) clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b0;
		repeat (reset_cycles) @(posedge clk_sys);
		#1 reset = 1'b1;
	end

endmodule

// File: verif/cart_control_checker.sv
// Cartridge control checker
// Watches the DUT ports, follows the SD sector requests and the cheat
// valid strobe cycle by cycle, and compares the results of each test
// with the expected values handed over by the testbench

`timescale 1ns/100ps

module cart_control_checker (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        load_active,
	input  logic [7:0]  load_index,
	input  logic        load_wr,
	input  logic [24:0] load_addr,
	input  logic [7:0]  rom_type,
	input  logic        rom_region,
	input  logic [23:0] rom_mask,
	input  logic [23:0] ram_mask,
	input  logic [31:0] cheat_flags,
	input  logic [31:0] cheat_addr,
	input  logic [31:0] cheat_compare,
	input  logic [31:0] cheat_replace,
	input  logic        cheat_valid,
	input  logic        cheat_reset,
	input  logic [31:0] sd_lba,
	input  logic        sd_rd,
	input  logic        sd_wr,
	input  logic        bk_busy,
	input  logic        bk_loading,
	input  logic        save_led,
	input  logic        core_hold,
	input  logic        test_start,
	input  logic        test_done,
	input  logic        report,
	input  logic        probe_led,
	input  logic        probe_creset,
	input  int          test_row,
	input  int          test_kind,
	input  logic [7:0]  exp_type,
	input  logic        exp_region,
	input  logic [23:0] exp_rom_mask,
	input  logic [23:0] exp_ram_mask,
	input  int          exp_sectors,
	input  logic        exp_write,
	input  logic [31:0] exp_flags,
	input  logic [31:0] exp_addr,
	input  logic [31:0] exp_compare,
	input  logic [31:0] exp_replace,
	output int          error_count
);

	int   tests_run;
	int   tests_failed;
	int   row_errors;
	int   rd_seen;
	int   wr_seen;
	int   valid_seen;
	logic old_rd;
	logic old_wr;
	logic valid_due;

	initial begin
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		row_errors   = 0;
		rd_seen      = 0;
		wr_seen      = 0;
		valid_seen   = 0;
	end

	task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] got);
		$display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
		row_errors++;
		error_count++;
	endtask

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
		if (exp !== got) begin
			value_error(name, exp, got);
		end
	endtask

	// ==================================================
	// Per-test results
	// ==================================================
	task automatic finish_test();
		case (test_kind)
			0: begin
				compare("rom_type", exp_type, rom_type);
				compare("rom_mask", exp_rom_mask, rom_mask);
				compare("ram_mask", exp_ram_mask, ram_mask);
				compare("rom_region", exp_region, rom_region);
			end
			1: begin
				compare("cheat_flags", exp_flags, cheat_flags);
				compare("cheat_addr", exp_addr, cheat_addr);
				compare("cheat_compare", exp_compare, cheat_compare);
				compare("cheat_replace", exp_replace, cheat_replace);
				compare("cheat_valid pulses", 1, valid_seen);
			end
			default: begin
				compare("bk_busy", 0, bk_busy);
				if (exp_write) begin
					compare("sd_wr sectors", exp_sectors, wr_seen);
					compare("sd_rd sectors", 0, rd_seen);
					compare("save_led", 0, save_led);
				end else begin
					compare("sd_rd sectors", exp_sectors, rd_seen);
					compare("sd_wr sectors", 0, wr_seen);
					compare("bk_loading", 0, bk_loading);
				end
			end
		endcase
		tests_run++;
		if (row_errors != 0) begin
			tests_failed++;
		end
		$display("Test %0d (kind %0d): %s", test_row, test_kind, (row_errors == 0) ? "ok" : "FAILED");
	endtask

	always @(posedge clk_sys) begin
		if (test_start) begin
			row_errors = 0;
			rd_seen    = 0;
			wr_seen    = 0;
			valid_seen = 0;
		end else if (reset) begin
			// Sectors must be requested in order from zero
			if (sd_rd && !old_rd) begin
				compare("sd_lba", rd_seen, sd_lba);
				compare("core_hold", 1, core_hold);
				rd_seen++;
			end
			if (sd_wr && !old_wr) begin
				compare("sd_lba", wr_seen, sd_lba);
				wr_seen++;
			end
			if (sd_rd && sd_wr) begin
				$display("Read and write requests were raised together at %0t", $time);
				row_errors++;
				error_count++;
			end
			// Loads keep bk_loading and core_hold up for the whole transfer
			if (bk_busy) begin
				compare("bk_loading", !exp_write, bk_loading);
				compare("core_hold", !exp_write, core_hold);
			end
			compare("cheat_valid", valid_due, cheat_valid);
			if (cheat_valid) begin
				valid_seen++;
			end
			if (probe_led) begin
				compare("save_led", 1, save_led);
			end
			if (probe_creset) begin
				compare("cheat_reset", 1, cheat_reset);
			end
			if (test_done) begin
				finish_test();
			end
		end
		if (report) begin
			$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
		end
		old_rd    <= sd_rd;
		old_wr    <= sd_wr;
		valid_due <= load_active && (&load_index) && load_wr && (load_addr[3:0] == 4'd14);
	end

endmodule

// File: verif/cart_control_tb.sv
// Cartridge control testbench
// Applies a table of header, cheat and backup RAM tests to the cartridge
// control top, answers SD requests with a small responder model and
// leaves the comparing to the checker

`timescale 1ns/100ps

module cart_control_tb;

	import cart_pkg::*;

	localparam int      n_rows     = 9;
	localparam int      row_cycles = 400;
	localparam realtime clk_period = 8.0;

	// ==================================================
	// Test table
	// ==================================================
	// Kind 0 header, 1 cheat, 2 backup; backup action 0 load, 1 autosave, 2 autoload
	int         row_kind    [n_rows] = '{0, 0, 0, 0, 1, 2, 2, 2, 2};
	int         row_mode    [n_rows] = '{0, 0, 3, 4, 0, 0, 0, 0, 0};
	logic [3:0] row_rom     [n_rows] = '{11, 0, 10, 13, 0, 12, 12, 12, 12};
	logic [3:0] row_ram     [n_rows] = '{5, 0, 3, 4, 0, 1, 2, 1, 0};
	logic [7:0] row_hi      [n_rows] = '{8'h21, 8'h30, 8'h55, 8'h66, 0, 0, 0, 0, 0};
	logic       row_region  [n_rows] = '{1, 0, 1, 0, 0, 0, 0, 0, 0};
	int         row_action  [n_rows] = '{0, 0, 0, 0, 0, 0, 1, 2, 2};
	logic [7:0] row_type    [n_rows] = '{8'h21, 8'h30, 8'h01, 8'h02, 0, 0, 0, 0, 0};
	int         row_rom_exp [n_rows] = '{11, 12, 10, 13, 0, 12, 12, 12, 12};
	int         row_sectors [n_rows] = '{0, 0, 0, 0, 0, 4, 8, 4, 0};

	logic clk_sys;
	logic reset;
	logic load_active;
	logic [7:0] load_index;
	logic [24:0] load_addr;
	logic [15:0] load_data;
	logic load_wr;
	header_mode_e header_mode;
	logic autosave_en;
	logic osd_open;
	logic bk_load_req;
	logic bk_save_req;
	logic sram_write;
	logic img_mounted;
	logic img_readonly;
	logic [63:0] img_size;
	logic sd_ack;
	logic [7:0] rom_type;
	logic rom_region;
	logic [23:0] rom_mask;
	logic [23:0] ram_mask;
	logic [31:0] cheat_flags;
	logic [31:0] cheat_addr;
	logic [31:0] cheat_compare;
	logic [31:0] cheat_replace;
	logic cheat_valid;
	logic cheat_reset;
	logic [31:0] sd_lba;
	logic sd_rd;
	logic sd_wr;
	logic bk_busy;
	logic bk_loading;
	logic save_led;
	logic core_hold;

	logic test_start;
	logic test_done;
	logic report;
	logic probe_led;
	logic probe_creset;
	int test_row;
	int test_kind;
	logic [7:0] exp_type;
	logic exp_region;
	logic [23:0] exp_rom_mask;
	logic [23:0] exp_ram_mask;
	int exp_sectors;
	logic exp_write;
	logic [31:0] exp_flags;
	logic [31:0] exp_addr;
	logic [31:0] exp_compare;
	logic [31:0] exp_replace;
	int error_count;
	int wait_errors;
	logic [15:0] lfsr;

	tb_clock_gen #(.period(clk_period), .reset_cycles(10)) u_clock (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	cart_control_top DUT (
		.clk_sys(clk_sys), .reset(reset), .load_active(load_active),
		.load_index(load_index), .load_addr(load_addr), .load_data(load_data),
		.load_wr(load_wr), .header_mode(header_mode), .autosave_en(autosave_en),
		.osd_open(osd_open), .bk_load_req(bk_load_req), .bk_save_req(bk_save_req),
		.sram_write(sram_write), .img_mounted(img_mounted), .img_readonly(img_readonly),
		.img_size(img_size), .sd_ack(sd_ack), .rom_type(rom_type),
		.rom_region(rom_region), .rom_mask(rom_mask), .ram_mask(ram_mask),
		.cheat_flags(cheat_flags), .cheat_addr(cheat_addr),
		.cheat_compare(cheat_compare), .cheat_replace(cheat_replace),
		.cheat_valid(cheat_valid), .cheat_reset(cheat_reset), .sd_lba(sd_lba),
		.sd_rd(sd_rd), .sd_wr(sd_wr), .bk_busy(bk_busy), .bk_loading(bk_loading),
		.save_led(save_led), .core_hold(core_hold)
	);

	cart_control_checker u_checker (
		.clk_sys(clk_sys), .reset(reset), .load_active(load_active),
		.load_index(load_index), .load_wr(load_wr), .load_addr(load_addr),
		.rom_type(rom_type), .rom_region(rom_region), .rom_mask(rom_mask),
		.ram_mask(ram_mask), .cheat_flags(cheat_flags), .cheat_addr(cheat_addr),
		.cheat_compare(cheat_compare), .cheat_replace(cheat_replace),
		.cheat_valid(cheat_valid), .cheat_reset(cheat_reset), .sd_lba(sd_lba),
		.sd_rd(sd_rd), .sd_wr(sd_wr), .bk_busy(bk_busy), .bk_loading(bk_loading),
		.save_led(save_led), .core_hold(core_hold), .test_start(test_start),
		.test_done(test_done), .report(report), .probe_led(probe_led),
		.probe_creset(probe_creset), .test_row(test_row), .test_kind(test_kind),
		.exp_type(exp_type), .exp_region(exp_region), .exp_rom_mask(exp_rom_mask),
		.exp_ram_mask(exp_ram_mask), .exp_sectors(exp_sectors),
		.exp_write(exp_write), .exp_flags(exp_flags), .exp_addr(exp_addr),
		.exp_compare(exp_compare), .exp_replace(exp_replace),
		.error_count(error_count)
	);

	// Galois LFSR stepped once per bit taken
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_word(output logic [15:0] w);
		w = '0;
		for (int i = 0; i < 16; i++) begin
			w = {lfsr[0], w[15:1]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Each size code doubles 1 KiB; a RAM code of zero means no RAM
	function automatic logic [23:0] size_mask(input int code, input logic is_ram);
		if (is_ram && code == 0) begin
			return '0;
		end
		return (24'd1024 << code) - 24'd1;
	endfunction

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		tick();
		load_addr = addr;
		load_data = data;
		load_wr   = 1'b1;
		tick();
		load_wr   = 1'b0;
	endtask

	task automatic start_load(input logic [7:0] index);
		tick();
		load_index  = index;
		load_active = 1'b1;
	endtask

	task automatic end_load();
		tick();
		load_active = 1'b0;
		load_index  = '0;
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (bk_busy !== level && n < limit) begin
			tick();
			n++;
		end
		if (bk_busy !== level) begin
			$display("Row %0d timed out waiting for bk_busy to become %0d", test_row, level);
			wait_errors++;
		end
	endtask

	// ==================================================
	// Row sequences
	// ==================================================
	task automatic run_header(input int r);
		logic [24:0] own;
		logic [24:0] other;
		own   = (row_mode[r] == 3) ? 25'(hirom_hdr_addr) : 25'(exhirom_hdr_addr);
		other = (row_mode[r] == 3) ? 25'(lorom_hdr_addr) : 25'(hirom_hdr_addr);
		start_load(8'h00);
		if (row_mode[r] == 0) begin
			write_word(25'd0, {row_hi[r], row_ram[r], row_rom[r]});
		end else begin
			write_word(25'd0, {row_hi[r], 8'hA7});
		end
		write_word(25'd2, {7'd0, row_region[r], 8'd0});
		if (row_mode[r] != 0) begin
			write_word(own, {4'd0, row_rom[r], 8'd0});
			write_word(own + 25'd2, {12'd0, row_ram[r]});
			// Decoy header at another mode's offset
			write_word(other, 16'h0900);
			write_word(other + 25'd2, 16'h000F);
		end
		end_load();
	endtask

	task automatic run_cheat();
		logic [15:0] w [8];
		start_load(8'hFF);
		for (int k = 0; k < 8; k++) begin
			random_word(w[k]);
			write_word(25'(2 * k), w[k]);
		end
		end_load();
		exp_flags   = {w[1], w[0]};
		exp_addr    = {w[3], w[2]};
		exp_compare = {w[5], w[4]};
		exp_replace = {w[7], w[6]};
		start_load(8'h00);
		probe_creset = 1'b1;
		tick();
		probe_creset = 1'b0;
		end_load();
	endtask

	task automatic run_backup(input int r);
		start_load(8'h00);
		write_word(25'd0, {8'h00, row_ram[r], row_rom[r]});
		tick();
		img_readonly = 1'b0;
		img_mounted  = 1'b1;
		img_size     = (row_action[r] == 2) ? 64'h8000 : 64'd0;
		tick();
		img_mounted = 1'b0;
		end_load();
		case (row_action[r])
			0: begin
				bk_load_req = 1'b1;
				wait_busy(1'b1, 20);
				bk_load_req = 1'b0;
				wait_busy(1'b0, row_cycles);
			end
			1: begin
				autosave_en = 1'b1;
				sram_write  = 1'b1;
				tick();
				sram_write = 1'b0;
				probe_led  = 1'b1;
				tick();
				probe_led = 1'b0;
				osd_open  = 1'b1;
				wait_busy(1'b1, 20);
				wait_busy(1'b0, row_cycles);
				osd_open = 1'b0;
			end
			default: begin
				if (row_sectors[r] != 0) begin
					wait_busy(1'b1, 20);
					wait_busy(1'b0, row_cycles);
				end else begin
					repeat (20) tick();
				end
			end
		endcase
		img_size = '0;
	endtask

	// SD device model that acknowledges each request after a few cycles
	initial begin
		sd_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (sd_rd || sd_wr) begin
				repeat (3) @(posedge clk_sys);
				#1 sd_ack = 1'b1;
				repeat (4) @(posedge clk_sys);
				#1 sd_ack = 1'b0;
			end
		end
	end

	initial begin
		#((n_rows * row_cycles + 20) * clk_period);
		$display("Watchdog expired before the test table was finished");
		$display("Test failures found");
		$finish;
	end

	initial begin
		load_active  = 0;
		load_index   = 0;
		load_addr    = 0;
		load_data    = 0;
		load_wr      = 0;
		header_mode  = hdr_auto;
		autosave_en  = 0;
		osd_open     = 0;
		bk_load_req  = 0;
		bk_save_req  = 0;
		sram_write   = 0;
		img_mounted  = 0;
		img_readonly = 1;
		img_size     = 0;
		test_start   = 0;
		test_done    = 0;
		report       = 0;
		probe_led    = 0;
		probe_creset = 0;
		test_row     = 0;
		test_kind    = 0;
		exp_type     = 0;
		exp_region   = 0;
		exp_rom_mask = 0;
		exp_ram_mask = 0;
		exp_sectors  = 0;
		exp_write    = 0;
		exp_flags    = 0;
		exp_addr     = 0;
		exp_compare  = 0;
		exp_replace  = 0;
		wait_errors  = 0;
		lfsr         = 16'd50;
		@(posedge reset);
		repeat (2) tick();
		for (int r = 0; r < n_rows; r++) begin
			header_mode  = header_mode_e'(row_mode[r]);
			test_row     = r;
			test_kind    = row_kind[r];
			exp_type     = row_type[r];
			exp_region   = row_region[r];
			exp_rom_mask = size_mask(row_rom_exp[r], 1'b0);
			exp_ram_mask = size_mask(row_ram[r], 1'b1);
			exp_sectors  = row_sectors[r];
			exp_write    = (row_action[r] == 1);
			test_start   = 1'b1;
			tick();
			test_start = 1'b0;
			case (row_kind[r])
				0: run_header(r);
				1: run_cheat();
				default: run_backup(r);
			endcase
			tick();
			test_done = 1'b1;
			tick();
			test_done = 1'b0;
		end
		report = 1'b1;
		tick();
		report = 1'b0;
		tick();
		if (error_count == 0 && wait_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: vlog.f
hdl/cart_pkg.sv
hdl/cart_header_detect.sv
hdl/cheat_code_loader.sv
hdl/backup_ram_sync.sv
hdl/cart_control_top.sv
verif/tb_clock_gen.sv
verif/cart_control_checker.sv
verif/cart_control_tb.sv

// File: Bender.yml
package:
  name: cart_control

sources:
  - hdl/cart_pkg.sv
  - hdl/cart_header_detect.sv
  - hdl/cheat_code_loader.sv
  - hdl/backup_ram_sync.sv
  - hdl/cart_control_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/cart_control_checker.sv
      - verif/cart_control_tb.sv
